// File: hw/ex_pkg.sv
/*
 * Shared definitions for the execution stage: word and intermediate-value
 * widths, ALU and multiplier/divider operator encodings, the
 * multiplier/divider FSM states, its latency and the intermediate-register structs
 */
package ex_pkg;

  typedef logic [31:0] word_t;
  // Word plus carry and sign bits used while iterating
  typedef logic [33:0] imd_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef enum logic [2:0] {
    MD_MUL,
    MD_MULH,
    MD_MULHSU,
    MD_MULHU,
    MD_DIV,
    MD_DIVU,
    MD_REM,
    MD_REMU
  } md_op_e;

  typedef enum logic [1:0] {
    MD_IDLE,
    MD_ITERATE,
    MD_FINISH
  } md_state_e;

  localparam int MD_ITERATIONS = 32;
  // Enabled cycles up to and including the valid cycle
  localparam int MD_LATENCY    = MD_ITERATIONS + 2;

  typedef struct packed {
    logic we1;
    logic we0;
    imd_t data1;
    imd_t data0;
  } imd_wr_t;

  typedef struct packed {
    imd_t q1;
    imd_t q0;
  } imd_rd_t;

endpackage

// File: hw/ex_alu.sv
/*
 * Combinational integer ALU: shared add/sub/compare adder, barrel
 * shifts, bitwise logic and the branch comparison result
 */
`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_op_e operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   adder_result_o,
  output ex_pkg::word_t   result_o,
  output logic            comparison_result_o
);

  logic          sub_op;
  ex_pkg::word_t adder_b;
  logic [32:0]   adder_ext;
  logic          is_equal;
  logic          lt_signed;
  logic          lt_unsigned;
  logic [4:0]    shamt;

  //////////////////////////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////////////////////////

  // Subtraction and every compare need a - b
  assign sub_op = operator_i inside {ex_pkg::ALU_SUB, ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU,
                                     ex_pkg::ALU_EQ, ex_pkg::ALU_NE, ex_pkg::ALU_LT,
                                     ex_pkg::ALU_GE, ex_pkg::ALU_LTU, ex_pkg::ALU_GEU};

  assign adder_b   = sub_op ? ~operand_b_i : operand_b_i;
  assign adder_ext = {1'b0, operand_a_i} + {1'b0, adder_b} + {32'b0, sub_op};

  assign adder_result_o = adder_ext[31:0];

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  assign is_equal = ~|(operand_a_i ^ operand_b_i);

  // No carry out of a - b means a borrow
  assign lt_unsigned = ~adder_ext[32];

  // Differing signs decide directly, else the difference sign does
  assign lt_signed = (operand_a_i[31] ^ operand_b_i[31]) ? operand_a_i[31] : adder_ext[31];

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_EQ:                    comparison_result_o = is_equal;
      ex_pkg::ALU_NE:                    comparison_result_o = ~is_equal;
      ex_pkg::ALU_LT, ex_pkg::ALU_SLT:   comparison_result_o = lt_signed;
      ex_pkg::ALU_GE:                    comparison_result_o = ~lt_signed;
      ex_pkg::ALU_LTU, ex_pkg::ALU_SLTU: comparison_result_o = lt_unsigned;
      ex_pkg::ALU_GEU:                   comparison_result_o = ~lt_unsigned;
      default:                           comparison_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////////////////////////

  assign shamt = operand_b_i[4:0];

  always_comb begin
    case (operator_i)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result_o = adder_ext[31:0];
      ex_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      ex_pkg::ALU_SRA:  result_o = $signed(operand_a_i) >>> shamt;
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_SLTU: result_o = {31'b0, comparison_result_o};
      // Branch compares only produce the decision
      default:          result_o = '0;
    endcase
  end

endmodule

// File: hw/ex_multdiv_iter.sv
/*
 * Iterative RV32M unit: shift-add multiplier and restoring divider
 * working on operand magnitudes, with signs applied in the finish cycle.
 * Partial results live in the external intermediate-value registers.
 */
`timescale 1ns/100ps

module ex_multdiv_iter (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            en_i,
  input  ex_pkg::md_op_e  operator_i,
  input  ex_pkg::word_t   op_a_i,
  input  ex_pkg::word_t   op_b_i,
  input  ex_pkg::imd_rd_t imd_rd_i,
  output ex_pkg::imd_wr_t imd_wr_o,
  output logic            valid_o,
  output ex_pkg::word_t   result_o
);

  ex_pkg::md_state_e state_q, state_d;
  logic [4:0]        cnt_q;
  ex_pkg::word_t     b_mag_q;
  logic              a_neg_q;
  logic              b_neg_q;

  logic              is_div;
  logic              a_signed;
  logic              b_signed;
  logic              a_neg;
  logic              b_neg;
  ex_pkg::word_t     a_mag;
  ex_pkg::word_t     b_mag;
  ex_pkg::imd_t      mul_sum;
  ex_pkg::imd_t      div_shift;
  ex_pkg::imd_t      div_diff;
  ex_pkg::imd_t      div_rem;
  logic              q_bit;
  logic [63:0]       prod;
  logic [63:0]       prod_s;
  logic              neg_quot;
  ex_pkg::word_t     quot_s;
  ex_pkg::word_t     rem_s;

  //////////////////////////////////////////////////////////////////////
  // Operand decode
  //////////////////////////////////////////////////////////////////////

  assign is_div   = operator_i inside {ex_pkg::MD_DIV, ex_pkg::MD_DIVU,
                                       ex_pkg::MD_REM, ex_pkg::MD_REMU};
  assign a_signed = operator_i inside {ex_pkg::MD_MULH, ex_pkg::MD_MULHSU,
                                       ex_pkg::MD_DIV, ex_pkg::MD_REM};
  assign b_signed = operator_i inside {ex_pkg::MD_MULH, ex_pkg::MD_DIV, ex_pkg::MD_REM};

  assign a_neg = a_signed & op_a_i[31];
  assign b_neg = b_signed & op_b_i[31];
  // 0x80000000 stays as an unsigned magnitude of 2^31
  assign a_mag = a_neg ? -op_a_i : op_a_i;
  assign b_mag = b_neg ? -op_b_i : op_b_i;

  //////////////////////////////////////////////////////////////////////
  // Iteration datapath
  //////////////////////////////////////////////////////////////////////

  // Multiply: reg 0 accumulates, reg 1 holds multiplier then low product
  assign mul_sum = imd_rd_i.q0 + (imd_rd_i.q1[0] ? {2'b00, b_mag_q} : '0);

  // Divide: reg 0 is the partial remainder, reg 1 dividend then quotient
  assign div_shift = {imd_rd_i.q0[32:0], imd_rd_i.q1[31]};
  assign div_diff  = div_shift - {2'b00, b_mag_q};
  assign q_bit     = ~div_diff[33];
  assign div_rem   = q_bit ? div_diff : div_shift;

  always_comb begin
    state_d  = state_q;
    imd_wr_o = '0;
    case (state_q)
      ex_pkg::MD_IDLE: begin
        if (en_i) begin
          imd_wr_o.we0   = 1'b1;
          imd_wr_o.we1   = 1'b1;
          imd_wr_o.data1 = {2'b00, a_mag};
          state_d        = ex_pkg::MD_ITERATE;
        end
      end
      ex_pkg::MD_ITERATE: begin
        imd_wr_o.we0 = 1'b1;
        imd_wr_o.we1 = 1'b1;
        if (is_div) begin
          imd_wr_o.data0 = div_rem;
          imd_wr_o.data1 = {2'b00, imd_rd_i.q1[30:0], q_bit};
        end else begin
          imd_wr_o.data0 = {1'b0, mul_sum[33:1]};
          imd_wr_o.data1 = {2'b00, mul_sum[0], imd_rd_i.q1[31:1]};
        end
        if (cnt_q == 5'(ex_pkg::MD_ITERATIONS - 1)) begin
          state_d = ex_pkg::MD_FINISH;
        end
      end
      default: state_d = ex_pkg::MD_IDLE;
    endcase
    // Dropping the enable abandons the operation
    if (!en_i) begin
      state_d = ex_pkg::MD_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ex_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ex_pkg::MD_ITERATE) begin
        cnt_q <= cnt_q + 5'd1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

  // Operand info captured on the first enabled cycle
  always_ff @(posedge clk_i) begin
    if (state_q == ex_pkg::MD_IDLE && en_i) begin
      b_mag_q <= b_mag;
      a_neg_q <= a_neg;
      b_neg_q <= b_neg;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Finish cycle sign fix and result select
  //////////////////////////////////////////////////////////////////////

  assign prod   = {imd_rd_i.q0[31:0], imd_rd_i.q1[31:0]};
  assign prod_s = (a_neg_q ^ b_neg_q) ? -prod : prod;

  // Divide by zero keeps the all-ones quotient
  assign neg_quot = (a_neg_q ^ b_neg_q) & (b_mag_q != '0);
  assign quot_s   = neg_quot ? -imd_rd_i.q1[31:0] : imd_rd_i.q1[31:0];
  assign rem_s    = a_neg_q ? -imd_rd_i.q0[31:0] : imd_rd_i.q0[31:0];

  always_comb begin
    case (operator_i)
      ex_pkg::MD_MUL:                  result_o = prod_s[31:0];
      ex_pkg::MD_DIV, ex_pkg::MD_DIVU: result_o = quot_s;
      ex_pkg::MD_REM, ex_pkg::MD_REMU: result_o = rem_s;
      default:                         result_o = prod_s[63:32];
    endcase
  end

  assign valid_o = (state_q == ex_pkg::MD_FINISH);

  // Intermediate registers hold their values while the unit is idle
  a_idle_no_write: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == ex_pkg::MD_IDLE && !en_i) |=> $stable(imd_rd_i));

  // Consumer must hold the enable through the whole operation
  a_en_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == ex_pkg::MD_ITERATE) |-> en_i);

endmodule

// File: hw/ex_imd_regs.sv
/*
 * Pair of 34-bit intermediate-value registers
 */
`timescale 1ns/100ps

module ex_imd_regs (
  input  logic            clk_i,
  input  logic            reset_i,
  input  ex_pkg::imd_wr_t imd_wr_i,
  output ex_pkg::imd_rd_t imd_rd_o
);

  ex_pkg::imd_t imd0_q;
  ex_pkg::imd_t imd1_q;

  // Each register has its own write enable
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      imd0_q <= '0;
      imd1_q <= '0;
    end else begin
      if (imd_wr_i.we0) begin
        imd0_q <= imd_wr_i.data0;
      end
      if (imd_wr_i.we1) begin
        imd1_q <= imd_wr_i.data1;
      end
    end
  end

  assign imd_rd_o.q0 = imd0_q;
  assign imd_rd_o.q1 = imd1_q;

  a_we_known: assert property (@(posedge clk_i) disable iff (reset_i)
    !$isunknown({imd_wr_i.we1, imd_wr_i.we0}));

endmodule

// File: hw/ex_block.sv
/*
 * Execution block with the ALU and the iterative multiplier/divider,
 * result and valid selection, and branch outputs
 */
`timescale 1ns/100ps

module ex_block (
  input  logic            clk_i,
  input  logic            reset_i,

  // ALU
  input  ex_pkg::alu_op_e alu_operator_i,
  input  ex_pkg::word_t   alu_operand_a_i,
  input  ex_pkg::word_t   alu_operand_b_i,

  // Multiplier/divider
  input  ex_pkg::md_op_e  md_operator_i,
  input  logic            md_en_i,
  input  ex_pkg::word_t   md_operand_a_i,
  input  ex_pkg::word_t   md_operand_b_i,

  // Intermediate-value registers
  input  ex_pkg::imd_rd_t imd_rd_i,
  output ex_pkg::imd_wr_t imd_wr_o,

  output ex_pkg::word_t   alu_adder_result_o,
  output ex_pkg::word_t   result_o,
  output ex_pkg::word_t   branch_target_o,
  output logic            branch_decision_o,
  output logic            ex_valid_o
);

  ex_pkg::word_t alu_result;
  logic          alu_cmp_result;
  ex_pkg::word_t md_result;
  logic          md_valid;

  ex_alu u_alu (
    .operator_i         (alu_operator_i),
    .operand_a_i        (alu_operand_a_i),
    .operand_b_i        (alu_operand_b_i),
    .adder_result_o     (alu_adder_result_o),
    .result_o           (alu_result),
    .comparison_result_o(alu_cmp_result)
  );

  ex_multdiv_iter u_multdiv (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .en_i      (md_en_i),
    .operator_i(md_operator_i),
    .op_a_i    (md_operand_a_i),
    .op_b_i    (md_operand_b_i),
    .imd_rd_i  (imd_rd_i),
    .imd_wr_o  (imd_wr_o),
    .valid_o   (md_valid),
    .result_o  (md_result)
  );

  assign branch_target_o   = alu_adder_result_o;
  assign branch_decision_o = alu_cmp_result;

  // ALU results are always ready in the same cycle
  assign result_o   = md_en_i ? md_result : alu_result;
  assign ex_valid_o = md_en_i ? md_valid : 1'b1;

  a_valid_known: assert property (@(posedge clk_i) disable iff (reset_i)
    !$isunknown(ex_valid_o));

endmodule

// File: hw/ex_stage.sv
/*
 * Execution stage top: execution block and its intermediate-value registers
 */
`timescale 1ns/100ps

module ex_stage (
  input  logic            clk_i,
  input  logic            reset_i,

  input  ex_pkg::alu_op_e alu_operator_i,
  input  ex_pkg::word_t   alu_operand_a_i,
  input  ex_pkg::word_t   alu_operand_b_i,

  input  ex_pkg::md_op_e  md_operator_i,
  input  logic            md_en_i,
  input  ex_pkg::word_t   md_operand_a_i,
  input  ex_pkg::word_t   md_operand_b_i,

  output ex_pkg::word_t   alu_adder_result_o,
  output ex_pkg::word_t   result_o,
  output ex_pkg::word_t   branch_target_o,
  output logic            branch_decision_o,
  output logic            ex_valid_o
);

  ex_pkg::imd_wr_t imd_wr;
  ex_pkg::imd_rd_t imd_rd;

  ex_block u_ex_block (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .alu_operator_i    (alu_operator_i),
    .alu_operand_a_i   (alu_operand_a_i),
    .alu_operand_b_i   (alu_operand_b_i),
    .md_operator_i     (md_operator_i),
    .md_en_i           (md_en_i),
    .md_operand_a_i    (md_operand_a_i),
    .md_operand_b_i    (md_operand_b_i),
    .imd_rd_i          (imd_rd),
    .imd_wr_o          (imd_wr),
    .alu_adder_result_o(alu_adder_result_o),
    .result_o          (result_o),
    .branch_target_o   (branch_target_o),
    .branch_decision_o (branch_decision_o),
    .ex_valid_o        (ex_valid_o)
  );

  ex_imd_regs u_imd_regs (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .imd_wr_i(imd_wr),
    .imd_rd_o(imd_rd)
  );

endmodule

// File: bench/ex_stage_tb.sv
/*
 * Testbench for the execution stage: stimulus table with reference models,
 * ALU, branch and multiplier/divider checks, latency check and watchdog
 */
`timescale 1ns/100ps

module ex_stage_tb;

  typedef struct packed {
    logic            is_md;
    ex_pkg::alu_op_e alu_op;
    ex_pkg::md_op_e  md_op;
    ex_pkg::word_t   a;
    ex_pkg::word_t   b;
    ex_pkg::word_t   exp;
  } entry_t;

  logic            clk;
  logic            reset;
  ex_pkg::alu_op_e alu_operator;
  ex_pkg::word_t   alu_a;
  ex_pkg::word_t   alu_b;
  ex_pkg::md_op_e  md_operator;
  logic            md_en;
  ex_pkg::word_t   md_a;
  ex_pkg::word_t   md_b;
  ex_pkg::word_t   adder_result;
  ex_pkg::word_t   result;
  ex_pkg::word_t   branch_target;
  logic            branch_decision;
  logic            ex_valid;

  entry_t tbl[$];
  int     seed = 21;
  int     errors = 0;
  int     checks = 0;
  int     cur = 0;
  logic   prev_md = 1'b0;

  ex_stage DUT (
    .clk_i             (clk),
    .reset_i           (reset),
    .alu_operator_i    (alu_operator),
    .alu_operand_a_i   (alu_a),
    .alu_operand_b_i   (alu_b),
    .md_operator_i     (md_operator),
    .md_en_i           (md_en),
    .md_operand_a_i    (md_a),
    .md_operand_b_i    (md_b),
    .alu_adder_result_o(adder_result),
    .result_o          (result),
    .branch_target_o   (branch_target),
    .branch_decision_o (branch_decision),
    .ex_valid_o        (ex_valid)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////////////////////////

  function automatic ex_pkg::word_t alu_model(ex_pkg::alu_op_e op, ex_pkg::word_t a,
                                              ex_pkg::word_t b);
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_SLL:  return a << b[4:0];
      ex_pkg::ALU_SRL:  return a >> b[4:0];
      ex_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
      ex_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ex_pkg::ALU_SLTU: return {31'b0, a < b};
      default:          return '0;
    endcase
  endfunction

  function automatic logic branch_model(ex_pkg::alu_op_e op, ex_pkg::word_t a,
                                        ex_pkg::word_t b);
    case (op)
      ex_pkg::ALU_EQ:                    return a == b;
      ex_pkg::ALU_NE:                    return a != b;
      ex_pkg::ALU_LT, ex_pkg::ALU_SLT:   return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:                    return $signed(a) >= $signed(b);
      ex_pkg::ALU_LTU, ex_pkg::ALU_SLTU: return a < b;
      ex_pkg::ALU_GEU:                   return a >= b;
      default:                           return 1'b0;
    endcase
  endfunction

  // Subtract for sub and every compare, add otherwise
  function automatic ex_pkg::word_t adder_model(ex_pkg::alu_op_e op, ex_pkg::word_t a,
                                                ex_pkg::word_t b);
    if (op == ex_pkg::ALU_SUB || op >= ex_pkg::ALU_SLT) begin
      return a - b;
    end
    return a + b;
  endfunction

  function automatic ex_pkg::word_t md_model(ex_pkg::md_op_e op, ex_pkg::word_t a,
                                             ex_pkg::word_t b);
    logic [63:0]        sa;
    logic [63:0]        ua;
    logic [63:0]        sb;
    logic [63:0]        ub;
    logic               ovf;
    logic signed [31:0] q;
    logic signed [31:0] r;
    sa  = {{32{a[31]}}, a};
    ua  = {32'b0, a};
    sb  = {{32{b[31]}}, b};
    ub  = {32'b0, b};
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    q   = '0;
    r   = '0;
    if (b != '0 && !ovf) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end
    case (op)
      ex_pkg::MD_MUL:    return 32'(ua * ub);
      ex_pkg::MD_MULH:   return 32'((sa * sb) >> 32);
      ex_pkg::MD_MULHSU: return 32'((sa * ub) >> 32);
      ex_pkg::MD_MULHU:  return 32'((ua * ub) >> 32);
      ex_pkg::MD_DIV:    return (b == '0) ? '1 : (ovf ? a : q);
      ex_pkg::MD_DIVU:   return (b == '0) ? '1 : a / b;
      ex_pkg::MD_REM:    return (b == '0) ? a : (ovf ? '0 : r);
      default:           return (b == '0) ? a : a % b;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic alu_entry(ex_pkg::alu_op_e op, ex_pkg::word_t a, ex_pkg::word_t b);
    entry_t e;
    e = '{is_md: 1'b0, alu_op: op, md_op: ex_pkg::MD_MUL, a: a, b: b,
          exp: alu_model(op, a, b)};
    tbl.push_back(e);
  endtask

  task automatic md_entry(ex_pkg::md_op_e op, ex_pkg::word_t a, ex_pkg::word_t b);
    entry_t e;
    e = '{is_md: 1'b1, alu_op: ex_pkg::ALU_ADD, md_op: op, a: a, b: b,
          exp: md_model(op, a, b)};
    tbl.push_back(e);
  endtask

  task automatic build_table();
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    alu_entry(ex_pkg::ALU_ADD, 32'h7fff_ffff, 32'd1);
    alu_entry(ex_pkg::ALU_SUB, 32'd0, 32'd1);
    alu_entry(ex_pkg::ALU_XOR, 32'ha5a5_a5a5, 32'h0ff0_0ff0);
    alu_entry(ex_pkg::ALU_OR, 32'ha5a5_0000, 32'h0000_5a5a);
    alu_entry(ex_pkg::ALU_AND, 32'hdead_beef, 32'hffff_0000);
    alu_entry(ex_pkg::ALU_SLL, 32'd1, 32'd31);
    alu_entry(ex_pkg::ALU_SRL, 32'h8000_0000, 32'd31);
    // Only the low five bits of b shift
    alu_entry(ex_pkg::ALU_SRA, 32'h8000_0000, 32'h0000_0024);
    alu_entry(ex_pkg::ALU_SLT, 32'hffff_ffff, 32'd1);
    alu_entry(ex_pkg::ALU_SLTU, 32'hffff_ffff, 32'd1);
    alu_entry(ex_pkg::ALU_EQ, 32'd5, 32'd5);
    alu_entry(ex_pkg::ALU_NE, 32'd5, 32'd5);
    alu_entry(ex_pkg::ALU_LT, 32'h8000_0000, 32'd1);
    alu_entry(ex_pkg::ALU_GE, 32'd1, 32'h8000_0000);
    alu_entry(ex_pkg::ALU_LTU, 32'd1, 32'h8000_0000);
    alu_entry(ex_pkg::ALU_GEU, 32'hffff_ffff, 32'hffff_ffff);
    md_entry(ex_pkg::MD_MUL, 32'd7, 32'hffff_fffd);
    md_entry(ex_pkg::MD_MULH, 32'h8000_0000, 32'h8000_0000);
    md_entry(ex_pkg::MD_MULH, 32'h8000_0000, 32'h7fff_ffff);
    md_entry(ex_pkg::MD_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
    md_entry(ex_pkg::MD_MULHU, 32'hffff_ffff, 32'hffff_ffff);
    alu_entry(ex_pkg::ALU_ADD, 32'd100, 32'd23);
    md_entry(ex_pkg::MD_DIV, 32'hffff_fff9, 32'd2);
    md_entry(ex_pkg::MD_DIVU, 32'd100, 32'd7);
    md_entry(ex_pkg::MD_REM, 32'hffff_fff9, 32'd2);
    md_entry(ex_pkg::MD_REMU, 32'd100, 32'd7);
    // Division by zero and signed overflow
    md_entry(ex_pkg::MD_DIV, 32'hffff_fffb, 32'd0);
    md_entry(ex_pkg::MD_DIVU, 32'h1234_5678, 32'd0);
    md_entry(ex_pkg::MD_REM, 32'hffff_fffb, 32'd0);
    md_entry(ex_pkg::MD_REMU, 32'h1234_5678, 32'd0);
    md_entry(ex_pkg::MD_DIV, 32'h8000_0000, 32'hffff_ffff);
    md_entry(ex_pkg::MD_REM, 32'h8000_0000, 32'hffff_ffff);
    alu_entry(ex_pkg::ALU_SUB, 32'd3, 32'd5);
    for (int i = 0; i < 40; i++) begin
      a = $random(seed);
      b = $random(seed);
      if (i % 10 == 4) begin
        b = '0;
      end
      if (i % 2 == 0) begin
        md_entry(ex_pkg::md_op_e'(3'($random(seed))), a, b);
      end else begin
        alu_entry(ex_pkg::alu_op_e'(4'($random(seed))), a, b);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(string name, ex_pkg::word_t got, ex_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h (entry %0d)", name, got, exp, cur);
    end
  endtask

  task automatic check_alu_outputs(entry_t e);
    @(negedge clk);
    check_value("ex_valid_o", 32'(ex_valid), 32'd1);
    if (e.alu_op <= ex_pkg::ALU_SLTU) begin
      check_value("result_o", result, e.exp);
    end
    check_value("branch_decision_o", 32'(branch_decision),
                32'(branch_model(e.alu_op, e.a, e.b)));
    check_value("branch_target_o", branch_target, adder_model(e.alu_op, e.a, e.b));
    check_value("alu_adder_result_o", adder_result, adder_model(e.alu_op, e.a, e.b));
  endtask

  task automatic await_md_result(entry_t e);
    int cycles;
    cycles = 0;
    // Cycle 1 is the first enabled cycle after the drive edge
    do begin
      @(negedge clk);
      cycles++;
    end while (!ex_valid && cycles < ex_pkg::MD_LATENCY + 4);
    if (!ex_valid) begin
      errors++;
      $display("Entry %0d: the multiplier/divider never raised ex_valid_o", cur);
    end else begin
      check_value("ex_valid_o latency", 32'(cycles - 1), 32'(ex_pkg::MD_LATENCY - 1));
      check_value("result_o", result, e.exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk          = 1'b0;
    reset        <= 1'b1;
    alu_operator <= ex_pkg::ALU_ADD;
    alu_a        <= 32'd3;
    alu_b        <= 32'd4;
    md_operator  <= ex_pkg::MD_MUL;
    md_en        <= 1'b0;
    md_a         <= '0;
    md_b         <= '0;
    build_table();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // Idle multiplier/divider leaves the ALU in charge
    @(negedge clk);
    check_value("ex_valid_o", 32'(ex_valid), 32'd1);
    check_value("result_o", result, 32'd7);
    for (int i = 0; i < tbl.size(); i++) begin
      cur = i;
      @(posedge clk);
      if (tbl[i].is_md && prev_md) begin
        // Enable drops for one cycle between back-to-back operations
        md_en <= 1'b0;
        @(posedge clk);
      end
      if (tbl[i].is_md) begin
        md_operator <= tbl[i].md_op;
        md_a        <= tbl[i].a;
        md_b        <= tbl[i].b;
        md_en       <= 1'b1;
        await_md_result(tbl[i]);
      end else begin
        alu_operator <= tbl[i].alu_op;
        alu_a        <= tbl[i].a;
        alu_b        <= tbl[i].b;
        md_en        <= 1'b0;
        check_alu_outputs(tbl[i]);
      end
      prev_md = tbl[i].is_md;
    end
    $display("Errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #1;
    #((tbl.size() * (ex_pkg::MD_LATENCY + 4) + 100) * 10);
    $display("Timeout: the test sequence did not complete in time");
    $display("Errors: %0d in %0d checks", errors, checks);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: project.f
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_multdiv_iter.sv
hw/ex_imd_regs.sv
hw/ex_block.sv
hw/ex_stage.sv
bench/ex_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execution stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module ex_stage_tb -Mdir obj_dir &&
  ./obj_dir/Vex_stage_tb | tee /dev/stderr | grep -x "Simulation finished: PASS" > /dev/null &&
  echo "Run passed" ||
  { echo "Run failed"; exit 1; }
